/* source/loader_pkg.sv */
// Shared constants for the cartridge loading logic.
// Holds download file-type codes, bus widths, cheat record layout
// and the palette loaded after reset. Modules import it as needed.

`default_nettype none

package loader_pkg;

	////////////////////
	// Download bus
	localparam int ioctl_addr_w = 25;
	localparam int ioctl_data_w = 16;
	localparam int filetype_w   = 8;

	// File types sent by the host
	localparam logic [filetype_w-1:0] ft_cart_gb  = 8'h01;
	localparam logic [filetype_w-1:0] ft_cart_gbc = 8'h41;
	localparam logic [filetype_w-1:0] ft_cart_alt = 8'h80;
	localparam logic [filetype_w-1:0] ft_palette  = 8'h03;
	localparam logic [filetype_w-1:0] ft_cheat    = 8'hFF;

	////////////////////
	// Cheat record, big fields first
	localparam int cheat_code_w      = 128;
	localparam int cheat_flags_lsb   = 96;
	localparam int cheat_addr_lsb    = 64;
	localparam int cheat_cmp_lsb     = 32;
	localparam int cheat_repl_lsb    = 0;
	localparam int cheat_last_offset = 14;

	////////////////////
	// Palette, four 24-bit entries from the top down
	localparam int palette_w   = 128;
	localparam int pal_color_w = 24;
	localparam logic [palette_w-1:0] palette_default = 128'h828214517356305A5F1A3B4900000000;

	////////////////////
	// Backup RAM and disk image
	localparam int sector_index_w  = 8;
	localparam int buff_addr_w     = 8;
	localparam int lba_w           = 32;
	localparam int bk_addr_w       = 17;
	localparam int rtc_timestamp_w = 32;
	localparam int rtc_saved_w     = 48;

endpackage

`default_nettype wire

/* source/cheat_code_loader.sv */
// Builds one cheat record out of eight 16-bit download words.
// Each word lands in the field picked by its byte offset and the valid
// strobe pulses on the clock after the final word of the record.
// gg_reset tells the cheat engine to drop its stored codes.

`default_nettype none

module cheat_code_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic code_download,
	input  logic cart_download,
	input  logic palette_download,
	input  logic ioctl_wr,
	input  logic [loader_pkg::ioctl_addr_w-1:0] ioctl_addr,
	input  logic [loader_pkg::ioctl_data_w-1:0] ioctl_dout,
	output logic [loader_pkg::cheat_code_w-1:0] gg_code,
	output logic gg_code_valid,
	output logic gg_reset
);
	import loader_pkg::*;

	logic code_wr;
	logic [3:0] word_offset;

	// Offsets 0..14 step through flags, address, compare and replace
	function automatic int field_lsb(input logic [1:0] slot);
		case (slot)
			2'd0: field_lsb = cheat_flags_lsb;
			2'd1: field_lsb = cheat_addr_lsb;
			2'd2: field_lsb = cheat_cmp_lsb;
			default: field_lsb = cheat_repl_lsb;
		endcase
	endfunction

	assign code_wr = code_download && ioctl_wr;
	assign word_offset = ioctl_addr[3:0];

	// Low word of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr && !word_offset[0]) begin
			gg_code[field_lsb(word_offset[3:2]) + ioctl_data_w*word_offset[1] +: ioctl_data_w]
				<= ioctl_dout;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			gg_code_valid <= 1'b0;
		end else begin
			gg_code_valid <= code_wr && (word_offset == 4'(cheat_last_offset));
		end
	end

	// Any new cartridge or palette also drops the loaded cheats
	assign gg_reset = (code_wr && ioctl_addr == '0) || cart_download || palette_download;

	valid_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		gg_code_valid |=> !gg_code_valid)
		else $error("gg_code_valid held for two cycles");

endmodule

`default_nettype wire

/* source/palette_loader.sv */
// Custom palette register for the LCD.
// A palette download shifts 16-bit words in from the bottom,
// each with its bytes swapped. Reset brings back the default palette.

`default_nettype none

module palette_loader (
	input  logic clk_sys,
	input  logic reset,
	input  logic palette_download,
	input  logic ioctl_wr,
	input  logic [loader_pkg::ioctl_data_w-1:0] ioctl_dout,
	output logic [loader_pkg::pal_color_w-1:0] pal1,
	output logic [loader_pkg::pal_color_w-1:0] pal2,
	output logic [loader_pkg::pal_color_w-1:0] pal3,
	output logic [loader_pkg::pal_color_w-1:0] pal4
);
	import loader_pkg::*;

	logic [palette_w-1:0] palette;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			palette <= palette_default;
		end else if (palette_download && ioctl_wr) begin
			// File stores the low byte first
			palette <= {palette[palette_w-ioctl_data_w-1:0], ioctl_dout[7:0], ioctl_dout[15:8]};
		end
	end

	// Entries from the top, bottom 32 bits are spare
	assign pal1 = palette[palette_w-1 -: pal_color_w];
	assign pal2 = palette[palette_w-pal_color_w-1 -: pal_color_w];
	assign pal3 = palette[palette_w-2*pal_color_w-1 -: pal_color_w];
	assign pal4 = palette[palette_w-3*pal_color_w-1 -: pal_color_w];

endmodule

`default_nettype wire

/* source/fast_forward_latch.sv */
// Fast-forward button handling.
// A short tap toggles fast-forward on and keeps it latched, a long hold
// only runs fast while the button stays down. The button is ignored
// during downloads and while the menu is open.

`default_nettype none

module fast_forward_latch #(
	parameter int FF_SHORT_PRESS = 3_200_000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic ff_button,
	input  logic ioctl_download,
	input  logic osd_status,
	output logic fast_forward
);
	localparam int CNT_W = $clog2(FF_SHORT_PRESS + 1);

	logic ff_effective;
	logic last_ff;
	logic ff_latch;
	logic ff_was_held;
	logic [CNT_W-1:0] press_count;

	assign ff_effective = ff_button && !ioctl_download && !osd_status;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			last_ff      <= 1'b0;
			ff_latch     <= 1'b0;
			ff_was_held  <= 1'b0;
			press_count  <= '0;
			fast_forward <= 1'b0;
		end else begin
			last_ff <= ff_effective;

			// Count stops at the short-press limit
			if (ff_effective && press_count != CNT_W'(FF_SHORT_PRESS))
				press_count <= press_count + 1'b1;

			if (!last_ff && ff_effective) begin
				ff_latch    <= 1'b0;
				press_count <= '0;
			end

			// A second tap turns it back off
			if (last_ff && !ff_effective) begin
				ff_was_held <= 1'b0;
				if (press_count < CNT_W'(FF_SHORT_PRESS) && !ff_was_held) begin
					ff_was_held <= 1'b1;
					ff_latch    <= 1'b1;
				end
			end

			fast_forward <= ff_effective || ff_latch;
		end
	end

endmodule

`default_nettype wire

/* source/backup_ram_sequencer.sv */
// Moves cartridge save RAM to and from the host disk image.
// One request per sector, starting at sector 0. When the cartridge has
// a real-time clock, one extra sector after the RAM holds its state.
// Loads start after a cartridge download or on request, saves on request
// or by autosave when the menu opens after the game wrote its RAM.

`default_nettype none

module backup_ram_sequencer (
	input  logic clk_sys,
	input  logic reset,
	input  logic cart_download,
	input  logic osd_status,
	input  logic load_req,
	input  logic save_req,
	input  logic autosave_en,
	input  logic cart_has_save,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic [63:0] img_size,
	input  logic [loader_pkg::sector_index_w-1:0] ram_mask_file,
	input  logic rtc_inuse,
	input  logic cram_wr,
	input  logic [loader_pkg::rtc_timestamp_w-1:0] rtc_timestamp,
	input  logic [loader_pkg::rtc_saved_w-1:0] rtc_saved_time,
	input  logic [15:0] bk_q,
	input  logic sd_ack,
	input  logic sd_buff_wr,
	input  logic [loader_pkg::buff_addr_w-1:0] sd_buff_addr,
	output logic [loader_pkg::lba_w-1:0] sd_lba,
	output logic sd_rd,
	output logic sd_wr,
	output logic [15:0] sd_buff_din,
	output logic [loader_pkg::bk_addr_w-1:0] bk_addr,
	output logic bk_wr,
	output logic bk_rtc_wr,
	output logic bk_loading,
	output logic sav_pending,
	output logic sav_supported
);
	import loader_pkg::*;

	logic [sector_index_w-1:0] sector;
	logic in_clock_sector;
	logic last_sector;
	logic bk_ena;
	logic new_load;
	logic bk_state;
	logic old_download;
	logic old_load;
	logic old_save;
	logic old_ack;
	logic bk_load;
	logic bk_save;
	logic download_start;
	logic download_end;

	////////////////////
	// Buffer side

	assign sector          = sd_lba[sector_index_w-1:0];
	assign in_clock_sector = sector > ram_mask_file;
	assign bk_addr         = bk_addr_w'({sector, sd_buff_addr});

	// Clock sector never reaches the save RAM
	assign bk_wr     = sd_buff_wr && sd_ack && !in_clock_sector;
	assign bk_rtc_wr = sd_buff_wr && sd_ack && in_clock_sector;

	always_comb begin
		if (!in_clock_sector) begin
			sd_buff_din = bk_q;
		end else begin
			case (sd_buff_addr)
				8'd0: sd_buff_din = rtc_timestamp[15:0];
				8'd1: sd_buff_din = rtc_timestamp[31:16];
				8'd2: sd_buff_din = rtc_saved_time[15:0];
				8'd3: sd_buff_din = rtc_saved_time[31:16];
				8'd4: sd_buff_din = rtc_saved_time[47:32];
				default: sd_buff_din = 16'hFFFF;
			endcase
		end
	end

	////////////////////
	// Enable and pending flags

	assign sav_supported  = cart_has_save && bk_ena;
	assign download_start = !old_download && cart_download;
	assign download_end   = old_download && !cart_download;
	assign bk_load        = load_req || new_load;
	assign bk_save        = save_req || (sav_pending && osd_status && autosave_en);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
			new_load     <= 1'b0;
			sav_pending  <= 1'b0;
		end else begin
			old_download <= cart_download;

			// Image gets mounted before the download finishes
			if (download_start)
				bk_ena <= 1'b0;
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			// Only a non-empty image is loaded after the download
			if (download_end && |img_size && bk_ena)
				new_load <= 1'b1;
			else if (bk_state)
				new_load <= 1'b0;

			if (cram_wr && !osd_status && sav_supported)
				sav_pending <= 1'b1;
			else if (bk_state)
				sav_pending <= 1'b0;
		end
	end

	////////////////////
	// Sector sequencing

	// Clock sector adds one more after the RAM sectors
	assign last_sector = rtc_inuse ? in_clock_sector : (sector >= ram_mask_file);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load   <= 1'b0;
			old_save   <= 1'b0;
			old_ack    <= 1'b0;
			bk_state   <= 1'b0;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;

			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			if (!bk_state) begin
				if (bk_ena && ((!old_load && bk_load) || (!old_save && bk_save))) begin
					bk_state   <= 1'b1;
					bk_loading <= bk_load;
					sd_lba     <= '0;
					sd_rd      <= bk_load;
					sd_wr      <= !bk_load;
				end
			end else if (old_ack && !sd_ack) begin
				if (last_sector) begin
					bk_state   <= 1'b0;
					bk_loading <= 1'b0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= bk_loading;
					sd_wr  <= !bk_loading;
				end
			end
		end
	end

	sd_req_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		sd_rd |-> !sd_wr)
		else $error("sd_rd and sd_wr raised together");

	bk_wr_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		bk_wr |-> !bk_rtc_wr)
		else $error("bk_wr and bk_rtc_wr raised together");

endmodule

`default_nettype wire

/* source/loader_top.sv */
// Top of the cartridge-side loading logic.
// Sorts host downloads by file type and feeds the cheat, palette,
// fast-forward and backup RAM units. Also drives core reset and the LED.

`default_nettype none

module loader_top #(
	parameter int FF_SHORT_PRESS = 3_200_000
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic osd_status,
	input  logic ioctl_download,
	input  logic ioctl_wr,
	input  logic [loader_pkg::ioctl_addr_w-1:0] ioctl_addr,
	input  logic [loader_pkg::ioctl_data_w-1:0] ioctl_dout,
	input  logic [loader_pkg::filetype_w-1:0] filetype,
	input  logic ff_button,
	input  logic load_req,
	input  logic save_req,
	input  logic autosave_en,
	input  logic cart_has_save,
	input  logic img_mounted,
	input  logic img_readonly,
	input  logic [63:0] img_size,
	input  logic [loader_pkg::sector_index_w-1:0] ram_mask_file,
	input  logic rtc_inuse,
	input  logic cram_wr,
	input  logic [loader_pkg::rtc_timestamp_w-1:0] rtc_timestamp,
	input  logic [loader_pkg::rtc_saved_w-1:0] rtc_saved_time,
	input  logic [15:0] bk_q,
	input  logic sd_ack,
	input  logic sd_buff_wr,
	input  logic [loader_pkg::buff_addr_w-1:0] sd_buff_addr,
	output logic [loader_pkg::cheat_code_w-1:0] gg_code,
	output logic gg_code_valid,
	output logic gg_reset,
	output logic [loader_pkg::pal_color_w-1:0] pal1,
	output logic [loader_pkg::pal_color_w-1:0] pal2,
	output logic [loader_pkg::pal_color_w-1:0] pal3,
	output logic [loader_pkg::pal_color_w-1:0] pal4,
	output logic fast_forward,
	output logic [loader_pkg::lba_w-1:0] sd_lba,
	output logic sd_rd,
	output logic sd_wr,
	output logic [15:0] sd_buff_din,
	output logic [loader_pkg::bk_addr_w-1:0] bk_addr,
	output logic bk_wr,
	output logic bk_rtc_wr,
	output logic sav_supported,
	output logic core_reset,
	output logic led_user
);
	import loader_pkg::*;

	logic cart_download;
	logic palette_download;
	logic code_download;
	logic bk_loading;
	logic sav_pending;

	////////////////////
	// Download classes
	assign cart_download = ioctl_download &&
		(filetype == ft_cart_gb || filetype == ft_cart_gbc || filetype == ft_cart_alt);
	assign palette_download = ioctl_download && filetype == ft_palette;
	assign code_download    = ioctl_download && filetype == ft_cheat;

	// Core stays in reset while a cartridge or its save is loading
	assign core_reset = reset || cart_download || bk_loading;
	assign led_user   = ioctl_download || sav_pending;

	cheat_code_loader u_cheat (
		.clk_sys(clk_sys), .reset(reset),
		.code_download(code_download), .cart_download(cart_download),
		.palette_download(palette_download), .ioctl_wr(ioctl_wr),
		.ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout),
		.gg_code(gg_code), .gg_code_valid(gg_code_valid), .gg_reset(gg_reset)
	);

	palette_loader u_palette (
		.clk_sys(clk_sys), .reset(reset),
		.palette_download(palette_download), .ioctl_wr(ioctl_wr), .ioctl_dout(ioctl_dout),
		.pal1(pal1), .pal2(pal2), .pal3(pal3), .pal4(pal4)
	);

	fast_forward_latch #(
		.FF_SHORT_PRESS(FF_SHORT_PRESS)
	) u_ff (
		.clk_sys(clk_sys), .reset(reset), .ff_button(ff_button),
		.ioctl_download(ioctl_download), .osd_status(osd_status),
		.fast_forward(fast_forward)
	);

	backup_ram_sequencer u_backup (
		.clk_sys(clk_sys), .reset(reset),
		.cart_download(cart_download), .osd_status(osd_status),
		.load_req(load_req), .save_req(save_req), .autosave_en(autosave_en),
		.cart_has_save(cart_has_save), .img_mounted(img_mounted),
		.img_readonly(img_readonly), .img_size(img_size),
		.ram_mask_file(ram_mask_file), .rtc_inuse(rtc_inuse), .cram_wr(cram_wr),
		.rtc_timestamp(rtc_timestamp), .rtc_saved_time(rtc_saved_time), .bk_q(bk_q),
		.sd_ack(sd_ack), .sd_buff_wr(sd_buff_wr), .sd_buff_addr(sd_buff_addr),
		.sd_lba(sd_lba), .sd_rd(sd_rd), .sd_wr(sd_wr), .sd_buff_din(sd_buff_din),
		.bk_addr(bk_addr), .bk_wr(bk_wr), .bk_rtc_wr(bk_rtc_wr),
		.bk_loading(bk_loading), .sav_pending(sav_pending),
		.sav_supported(sav_supported)
	);

endmodule

`default_nettype wire

/* bench/tb_loader_top.sv */
// Testbench for the cartridge loading logic.
// Sends palette, cheat and cartridge downloads, plays the disk host for
// backup RAM transfers and works the fast-forward button. Assertions
// compare the DUT against models built from the loading rules.

`default_nettype none

module tb_loader_top;

	localparam int clk_period = 40;
	localparam int wait_limit = 100;
	localparam logic [127:0] pal_reset_value = 128'h828214517356305A5F1A3B4900000000;

	logic clk_sys, reset, osd_status, ioctl_download, ioctl_wr;
	logic [24:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic [7:0] filetype;
	logic ff_button, load_req, save_req, autosave_en;
	logic cart_has_save, img_mounted, img_readonly;
	logic [63:0] img_size;
	logic [7:0] ram_mask_file;
	logic rtc_inuse, cram_wr;
	logic [31:0] rtc_timestamp;
	logic [47:0] rtc_saved_time;
	logic [15:0] bk_q;
	logic sd_ack, sd_buff_wr;
	logic [7:0] sd_buff_addr;
	logic [127:0] gg_code;
	logic gg_code_valid, gg_reset;
	logic [23:0] pal1, pal2, pal3, pal4;
	logic fast_forward;
	logic [31:0] sd_lba;
	logic sd_rd, sd_wr;
	logic [15:0] sd_buff_din;
	logic [16:0] bk_addr;
	logic bk_wr, bk_rtc_wr, sav_supported, core_reset, led_user;

	logic [31:0] rng_state;
	logic [7:0] host_sector;
	logic saving;
	logic expect_loading;
	logic cheat_first_wr, cheat_last_wr, cart_dl;

	loader_top #(.FF_SHORT_PRESS(20)) uut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period/2) clk_sys = ~clk_sys;
	end

	////////////////////
	// Helpers

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		xorshift32 = y ^ (y << 5);
	endfunction

	// Flags, address, compare, replace from the top, low word first
	function automatic int cheat_field_lsb(input int offset);
		cheat_field_lsb = 96 - 32*(offset/4) + 16*((offset/2) % 2);
	endfunction

	function automatic logic [15:0] expected_din(input logic [7:0] sector, input logic [7:0] addr);
		if (sector <= ram_mask_file) begin
			expected_din = bk_q;
		end else begin
			case (addr)
				8'd0: expected_din = rtc_timestamp[15:0];
				8'd1: expected_din = rtc_timestamp[31:16];
				8'd2: expected_din = rtc_saved_time[15:0];
				8'd3: expected_din = rtc_saved_time[31:16];
				8'd4: expected_din = rtc_saved_time[47:32];
				default: expected_din = 16'hFFFF;
			endcase
		end
	endfunction

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [127:0] expected,
		input logic [127:0] actual);
		assert (actual === expected)
		else stop_with_failure($sformatf("FAIL time=%0t %s expected=%0h actual=%0h",
			$time, name, expected, actual));
	endtask

	// One write strobe, returns on the next falling edge
	task automatic download_write(input logic [24:0] addr, input logic [15:0] data);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
	endtask

	// Disk host: ack each request, stream six words, drop the ack
	task automatic run_transfer(input logic load, input int sectors);
		int cycles;
		int s;
		int a;
		saving = !load;
		for (s = 0; s < sectors; s++) begin
			host_sector = 8'(s);
			cycles = 0;
			while (!(sd_rd || sd_wr)) begin
				@(negedge clk_sys);
				cycles++;
				if (cycles > wait_limit)
					stop_with_failure($sformatf("No disk request arrived for sector %0d", s));
			end
			expect_loading = load;
			check_value("sd_rd", load, sd_rd);
			check_value("sd_wr", !load, sd_wr);
			check_value("sd_lba", s, sd_lba);
			sd_ack = 1'b1;
			@(negedge clk_sys);
			check_value("sd_rd", 0, sd_rd);
			check_value("sd_wr", 0, sd_wr);
			for (a = 0; a < 6; a++) begin
				rng_state    = xorshift32(rng_state);
				bk_q         = rng_state[15:0];
				sd_buff_addr = 8'(a);
				sd_buff_wr   = 1'b1;
				@(negedge clk_sys);
			end
			sd_buff_wr = 1'b0;
			sd_ack     = 1'b0;
			@(negedge clk_sys);
		end
		expect_loading = 1'b0;
		saving = 1'b0;
		// Nothing may follow the last sector
		repeat (10) begin
			check_value("sd_rd", 0, sd_rd);
			check_value("sd_wr", 0, sd_wr);
			check_value("core_reset", 0, core_reset);
			@(negedge clk_sys);
		end
	endtask

	////////////////////
	// Assertions

	assign cheat_first_wr = ioctl_download && ioctl_wr && filetype == 8'hFF && ioctl_addr == 0;
	assign cheat_last_wr  = ioctl_download && ioctl_wr && filetype == 8'hFF && ioctl_addr == 14;
	assign cart_dl = ioctl_download && (filetype == 8'h01 || filetype == 8'h41 || filetype == 8'h80);

	valid_after_last_word: assert property (@(posedge clk_sys) disable iff (reset)
		gg_code_valid == $past(cheat_last_wr))
		else check_value("gg_code_valid", !$sampled(gg_code_valid), $sampled(gg_code_valid));

	cheat_engine_reset: assert property (@(posedge clk_sys) disable iff (reset)
		(cheat_first_wr || cart_dl) |-> gg_reset)
		else check_value("gg_reset", 1, $sampled(gg_reset));

	ram_write_routing: assert property (@(posedge clk_sys) disable iff (reset)
		bk_wr == (sd_ack && sd_buff_wr && host_sector <= ram_mask_file))
		else check_value("bk_wr", !$sampled(bk_wr), $sampled(bk_wr));

	// RAM word address is the sector on top of the buffer address
	ram_write_address: assert property (@(posedge clk_sys) disable iff (reset)
		(sd_ack && sd_buff_wr && host_sector <= ram_mask_file) |->
			bk_addr == {1'b0, host_sector, sd_buff_addr})
		else check_value("bk_addr", {1'b0, host_sector, sd_buff_addr}, $sampled(bk_addr));

	clock_write_routing: assert property (@(posedge clk_sys) disable iff (reset)
		bk_rtc_wr == (sd_ack && sd_buff_wr && host_sector > ram_mask_file))
		else check_value("bk_rtc_wr", !$sampled(bk_rtc_wr), $sampled(bk_rtc_wr));

	save_data: assert property (@(posedge clk_sys) disable iff (reset)
		(saving && sd_ack && sd_buff_wr) |-> sd_buff_din == expected_din(host_sector, sd_buff_addr))
		else check_value("sd_buff_din", expected_din(host_sector, sd_buff_addr),
			$sampled(sd_buff_din));

	core_held_in_reset: assert property (@(posedge clk_sys) disable iff (reset)
		expect_loading |-> core_reset)
		else check_value("core_reset", 1, $sampled(core_reset));

	////////////////////
	// Stimulus

	initial begin
		int i;
		logic [15:0] word;
		logic [127:0] pal_model;
		logic [127:0] code_model;
		reset = 1'b1;
		{osd_status, ioctl_download, ioctl_wr, ff_button} = '0;
		{load_req, save_req, autosave_en, cram_wr, rtc_inuse} = '0;
		{sd_ack, sd_buff_wr, sd_buff_addr, bk_q} = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		filetype   = '0;
		cart_has_save = 1'b1;
		img_mounted   = 1'b1;
		img_readonly  = 1'b0;
		img_size      = 64'h8000;
		ram_mask_file = 8'd3;
		host_sector = '0;
		saving = 1'b0;
		expect_loading = 1'b0;
		rng_state = 32'h9c3a;
		rng_state = xorshift32(rng_state);
		rtc_timestamp = rng_state;
		rng_state = xorshift32(rng_state);
		rtc_saved_time = {rng_state[15:0], xorshift32(rng_state)};
		repeat (3) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);

		check_value("sd_rd", 0, sd_rd);
		check_value("sd_wr", 0, sd_wr);
		check_value("gg_code_valid", 0, gg_code_valid);
		check_value("fast_forward", 0, fast_forward);
		check_value("core_reset", 0, core_reset);
		check_value("led_user", 0, led_user);
		check_value("sav_supported", 0, sav_supported);

		// Palette shifts in byte-swapped words
		pal_model = pal_reset_value;
		check_value("pal1..pal4", pal_model[127:32], {pal1, pal2, pal3, pal4});
		filetype = 8'h03;
		ioctl_download = 1'b1;
		for (i = 0; i < 8; i++) begin
			rng_state = xorshift32(rng_state);
			word = rng_state[15:0];
			download_write(25'(2*i), word);
			pal_model = {pal_model[111:0], word[7:0], word[15:8]};
			check_value("pal1..pal4", pal_model[127:32], {pal1, pal2, pal3, pal4});
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;

		// Cheat record
		filetype = 8'hFF;
		ioctl_download = 1'b1;
		code_model = '0;
		for (i = 0; i < 8; i++) begin
			rng_state = xorshift32(rng_state);
			word = rng_state[15:0];
			download_write(25'(2*i), word);
			code_model[cheat_field_lsb(2*i) +: 16] = word;
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		check_value("gg_code", code_model, gg_code);

		// Cartridge download loads four RAM sectors
		filetype = 8'h01;
		ioctl_download = 1'b1;
		for (i = 0; i < 4; i++) begin
			rng_state = xorshift32(rng_state);
			download_write(25'(2*i), rng_state[15:0]);
			@(negedge clk_sys);
		end
		ioctl_download = 1'b0;
		check_value("sav_supported", 1, sav_supported);
		run_transfer(1'b1, 4);

		// Save with the clock sector
		rtc_inuse = 1'b1;
		save_req = 1'b1;
		@(negedge clk_sys);
		save_req = 1'b0;
		run_transfer(1'b0, 5);

		// Autosave when the menu opens
		cram_wr = 1'b1;
		@(negedge clk_sys);
		cram_wr = 1'b0;
		check_value("led_user", 1, led_user);
		autosave_en = 1'b1;
		osd_status = 1'b1;
		run_transfer(1'b0, 5);
		check_value("led_user", 0, led_user);
		osd_status = 1'b0;
		@(negedge clk_sys);

		// Short tap latches, long hold does not
		ff_button = 1'b1;
		repeat (5) @(negedge clk_sys);
		ff_button = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_value("fast_forward", 1, fast_forward);

		// Second tap turns it off
		ff_button = 1'b1;
		repeat (5) @(negedge clk_sys);
		ff_button = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_value("fast_forward", 0, fast_forward);

		ff_button = 1'b1;
		repeat (40) @(negedge clk_sys);
		ff_button = 1'b0;
		repeat (4) @(negedge clk_sys);
		check_value("fast_forward", 0, fast_forward);

		// Button ignored during a download
		filetype = 8'h00;
		ioctl_download = 1'b1;
		ff_button = 1'b1;
		repeat (30) begin
			@(negedge clk_sys);
			check_value("fast_forward", 0, fast_forward);
		end
		ff_button = 1'b0;
		@(negedge clk_sys);
		ioctl_download = 1'b0;
		repeat (4) begin
			@(negedge clk_sys);
			check_value("fast_forward", 0, fast_forward);
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
source/loader_pkg.sv
source/cheat_code_loader.sv
source/palette_loader.sv
source/fast_forward_latch.sv
source/backup_ram_sequencer.sv
source/loader_top.sv
bench/tb_loader_top.sv
